// ==== design/monitor_macros.svh ====
// Widths and counts shared by the package and the RTL
// MON_WIDTH must be a whole multiple of PORT_WIDTH
`ifndef MONITOR_MACROS_SVH
`define MONITOR_MACROS_SVH

// ==============================
// Datapath widths
// ==============================
`define MON_WIDTH      384
`define PORT_WIDTH     128
`define CFG_WIDTH      256

// ==============================
// Counts
// ==============================
`define MON_SRC_NUM    4
`define MON_MAX_BEATS  3

// Config word field positions
`define CFG_OP_MSB     1
`define CFG_OP_LSB     0
`define CFG_SRC_MSB    3
`define CFG_SRC_LSB    2
`define CFG_CNT_MSB    5
`define CFG_CNT_LSB    4

`endif

// ==== design/monitor_pkg.sv ====
// Types for the debug monitor
// Opcode encoding is fixed by the control unit, bits 1:0 of the config word
`include "monitor_macros.svh"

package monitor_pkg;

    // ==============================
    // Width typedefs
    // ==============================

    // One status bank snapshot
    typedef logic [`MON_WIDTH-1:0] mon_word_t;
    // One off-chip beat
    typedef logic [`PORT_WIDTH-1:0] port_word_t;
    // Raw config word from the control unit
    typedef logic [`CFG_WIDTH-1:0] cfg_word_t;
    // Bank index
    typedef logic [$clog2(`MON_SRC_NUM)-1:0] src_sel_t;
    // Beat count, 1 to MON_MAX_BEATS once decoded
    typedef logic [$clog2(`MON_MAX_BEATS+1)-1:0] beat_cnt_t;

    // ==============================
    // Enums
    // ==============================

    // Config opcodes
    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_START = 2'b01,
        OP_ABORT = 2'b10,
        OP_RSVD  = 2'b11
    } mon_op_t;

    // Frame controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_LOAD = 2'b01,
        ST_OUT  = 2'b10
    } mon_state_t;

endpackage

// ==== design/mon_cfg_regs.sv ====
// Config word decoder; only ABORT is taken while a frame runs
// A START seen while busy is back-pressured, never queued
`include "monitor_macros.svh"

module mon_cfg_regs
    import monitor_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Config channel from the control unit
    input  logic      cfg_vld,
    input  cfg_word_t cfg_info,
    output logic      cfg_rdy,

    // Frame controller side
    input  logic      busy,
    output logic      start,
    output logic      abort,
    output src_sel_t  src_sel,
    output beat_cnt_t beat_cnt
);

    // ==============================
    // Field decode
    // ==============================
    mon_op_t   op;
    src_sel_t  src_fld;
    beat_cnt_t cnt_fld;
    logic      cfg_acc;
    logic      busy_any;

    assign op      = mon_op_t'(cfg_info[`CFG_OP_MSB:`CFG_OP_LSB]);
    assign src_fld = cfg_info[`CFG_SRC_MSB:`CFG_SRC_LSB];
    assign cnt_fld = cfg_info[`CFG_CNT_MSB:`CFG_CNT_LSB];

    // ==============================
    // Handshake
    // ==============================

    // Start pulse in flight counts as busy
    // Closes the one-cycle gap before the FSM leaves idle
    assign busy_any = busy | start;

    // Idle takes any word, busy takes only ABORT
    assign cfg_rdy  = ~busy_any | (op == OP_ABORT);
    assign cfg_acc  = cfg_vld & cfg_rdy;

    // ==============================
    // Command pulses
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            abort <= 1'b0;
        end else begin
            // One cycle each
            start <= cfg_acc & (op == OP_START);
            abort <= cfg_acc & (op == OP_ABORT);
        end
    end

    // ==============================
    // Request fields
    // ==============================

    // Held until the next accepted START
    // NOP, RSVD and ABORT leave them alone
    always_ff @(posedge clk) begin
        if (cfg_acc && (op == OP_START)) begin
            src_sel <= src_fld;
            // Count of zero asks for a full snapshot
            if (cnt_fld == '0) begin
                beat_cnt <= beat_cnt_t'(`MON_MAX_BEATS);
            end else begin
                beat_cnt <= cnt_fld;
            end
        end
    end

endmodule

// ==== design/mon_ctrl.sv ====
// Frame FSM: idle, one load cycle, then out until done or abort
// Bank data is sampled by the shifter at the end of the load cycle
module mon_ctrl
    import monitor_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // From the config block
    input  logic      start,
    input  logic      abort,
    input  src_sel_t  src_sel,
    input  beat_cnt_t beat_cnt_in,

    // Status banks
    input  mon_word_t mon_dat0,
    input  mon_word_t mon_dat1,
    input  mon_word_t mon_dat2,
    input  mon_word_t mon_dat3,

    // Shifter side
    input  logic      done,
    output logic      busy,
    output logic      load,
    output logic      clear,
    output mon_word_t snapshot,
    output beat_cnt_t beat_cnt
);

    mon_state_t state;
    mon_state_t state_nxt;
    src_sel_t   frame_src;
    beat_cnt_t  frame_cnt;

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) state_nxt = ST_LOAD;
            end
            // Abort here means the shifter never loads
            ST_LOAD: begin
                state_nxt = abort ? ST_IDLE : ST_OUT;
            end
            // Done is the last beat handshake itself
            ST_OUT: begin
                if (abort || done) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==============================
    // Frame parameters
    // ==============================

    // Latched as the frame opens
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            frame_src <= src_sel;
            frame_cnt <= beat_cnt_in;
        end
    end

    // Bank select
    always_comb begin
        case (frame_src)
            2'd0:    snapshot = mon_dat0;
            2'd1:    snapshot = mon_dat1;
            2'd2:    snapshot = mon_dat2;
            default: snapshot = mon_dat3;
        endcase
    end

    // ==============================
    // Outputs
    // ==============================
    assign busy     = (state != ST_IDLE);
    assign load     = (state == ST_LOAD) & ~abort;
    // Flush the shifter on abort of an open frame
    assign clear    = abort & busy;
    assign beat_cnt = frame_cnt;

endmodule

// ==== design/mon_piso.sv ====
// Parallel-in serial-out shifter, beat 0 is the low slice of the word
// DATA_IN_WIDTH must be a multiple of DATA_OUT_WIDTH; clear beats load
`include "monitor_macros.svh"

module mon_piso
    import monitor_pkg::*;
#(
    parameter int DATA_IN_WIDTH  = `MON_WIDTH,
    parameter int DATA_OUT_WIDTH = `PORT_WIDTH
) (
    input  logic       clk,
    input  logic       rst_n,

    // Control from the frame FSM
    input  logic       load,
    input  logic       clear,
    input  mon_word_t  in_dat,
    input  beat_cnt_t  beat_cnt,

    // Off-chip beat stream
    output port_word_t out_dat,
    output logic       out_vld,
    output logic       out_last,
    input  logic       out_rdy,

    // Last beat taken
    output logic       done
);

    // ==============================
    // Storage
    // ==============================
    logic [DATA_IN_WIDTH-1:0] shreg;
    beat_cnt_t                rem;
    logic                     xfer;
    logic                     one_left;

    assign xfer     = out_vld & out_rdy;
    assign one_left = (rem == beat_cnt_t'(1));

    // ==============================
    // Beat bookkeeping
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
            rem     <= '0;
        end else if (clear) begin
            // Drop whatever is left of the frame
            out_vld <= 1'b0;
            rem     <= '0;
        end else if (load) begin
            out_vld <= (beat_cnt != '0);
            rem     <= beat_cnt;
        end else if (xfer) begin
            rem <= rem - beat_cnt_t'(1);
            if (one_left) begin
                out_vld <= 1'b0;
            end
        end
    end

    // ==============================
    // Data path
    // ==============================

    // Only moves on a handshake so data holds under stall
    always_ff @(posedge clk) begin
        if (load && !clear) begin
            shreg <= in_dat;
        end else if (xfer) begin
            shreg <= shreg >> DATA_OUT_WIDTH;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    // Current beat sits in the low slice
    assign out_dat  = shreg[DATA_OUT_WIDTH-1:0];
    // Last flag from the counter, stable while stalled
    assign out_last = out_vld & one_left;
    assign done     = xfer & one_left;

endmodule

// ==== design/monitor_top.sv ====
// Debug monitor top: config decode, frame FSM and beat shifter
// Status banks must be stable around the load edge of a frame
`include "monitor_macros.svh"

module monitor_top
    import monitor_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Config channel
    input  logic       cfg_vld,
    input  cfg_word_t  cfg_info,
    output logic       cfg_rdy,

    // Status banks
    input  mon_word_t  mon_dat0,
    input  mon_word_t  mon_dat1,
    input  mon_word_t  mon_dat2,
    input  mon_word_t  mon_dat3,

    // Off-chip beats
    output port_word_t out_dat,
    output logic       out_vld,
    output logic       out_last,
    input  logic       out_rdy
);

    // ==============================
    // Internal wires
    // ==============================

    // Config block to FSM
    logic      start;
    logic      abort;
    src_sel_t  src_sel;
    beat_cnt_t req_cnt;
    logic      busy;

    // FSM to shifter
    logic      load;
    logic      clear;
    mon_word_t snapshot;
    beat_cnt_t frame_cnt;
    logic      done;

    // ==============================
    // Instances
    // ==============================
    mon_cfg_regs i_cfg_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg_info (cfg_info),
        .cfg_rdy  (cfg_rdy),
        .busy     (busy),
        .start    (start),
        .abort    (abort),
        .src_sel  (src_sel),
        .beat_cnt (req_cnt)
    );

    mon_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .abort       (abort),
        .src_sel     (src_sel),
        .beat_cnt_in (req_cnt),
        .mon_dat0    (mon_dat0),
        .mon_dat1    (mon_dat1),
        .mon_dat2    (mon_dat2),
        .mon_dat3    (mon_dat3),
        .done        (done),
        .busy        (busy),
        .load        (load),
        .clear       (clear),
        .snapshot    (snapshot),
        .beat_cnt    (frame_cnt)
    );

    mon_piso #(
        .DATA_IN_WIDTH  (`MON_WIDTH),
        .DATA_OUT_WIDTH (`PORT_WIDTH)
    ) i_piso (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .clear    (clear),
        .in_dat   (snapshot),
        .beat_cnt (frame_cnt),
        .out_dat  (out_dat),
        .out_vld  (out_vld),
        .out_last (out_last),
        .out_rdy  (out_rdy),
        .done     (done)
    );

endmodule

// ==== verification/monitor_tb.sv ====
// Self-checking testbench for monitor_top with stimulus from a 16-bit LFSR
// Assumes one frame at a time and no ABORT inside the load cycle of a frame
`include "monitor_macros.svh"

module monitor_tb
    import monitor_pkg::*;
();

    localparam int FRAME_TOTAL     = 22;
    localparam int FRAME_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = FRAME_TOTAL * FRAME_CYCLES + 500;

    logic       clk;
    logic       rst_n;
    logic       cfg_vld;
    cfg_word_t  cfg_info;
    logic       cfg_rdy;
    mon_word_t  mon_dat0;
    mon_word_t  mon_dat1;
    mon_word_t  mon_dat2;
    mon_word_t  mon_dat3;
    port_word_t out_dat;
    logic       out_vld;
    logic       out_last;
    logic       out_rdy;
    logic [15:0] lfsr;

    // Reference model state
    port_word_t exp_q [$];
    logic       frame_open;
    logic       flush_due;
    int         load_age;
    src_sel_t   pend_src;
    beat_cnt_t  pend_cnt;
    logic       exp_have;
    port_word_t exp_dat;
    logic       exp_last;
    logic       prev_stall;
    port_word_t prev_dat;
    logic       prev_last;
    mon_op_t    cfg_op;

    assign cfg_op = mon_op_t'(cfg_info[`CFG_OP_MSB:`CFG_OP_LSB]);

    monitor_top i_monitor_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg_info (cfg_info),
        .cfg_rdy  (cfg_rdy),
        .mon_dat0 (mon_dat0),
        .mon_dat1 (mon_dat1),
        .mon_dat2 (mon_dat2),
        .mon_dat3 (mon_dat3),
        .out_dat  (out_dat),
        .out_vld  (out_vld),
        .out_last (out_last),
        .out_rdy  (out_rdy)
    );

    always #5 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [127:0] expv,
                              input logic [127:0] actv);
        stop_run($sformatf("FAIL %s: expected %0h, actual %0h", name, expv, actv));
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Single bit for the sink ready
    function automatic logic take_bit();
        logic [31:0] r;
        r = take_bits(1);
        return r[0];
    endfunction

    function automatic mon_word_t bank_word(input src_sel_t src);
        case (src)
            2'd0:    return mon_dat0;
            2'd1:    return mon_dat1;
            2'd2:    return mon_dat2;
            default: return mon_dat3;
        endcase
    endfunction

    task automatic fill_banks();
        mon_word_t w [`MON_SRC_NUM];
        for (int b = 0; b < `MON_SRC_NUM; b++) begin
            for (int k = 0; k < `MON_WIDTH / 32; k++) begin
                w[b][k*32 +: 32] = take_bits(32);
            end
        end
        mon_dat0 = w[0];
        mon_dat1 = w[1];
        mon_dat2 = w[2];
        mon_dat3 = w[3];
    endtask

    // Hold the word until accepted while the sink stays random
    task automatic send_cfg(input mon_op_t op, input src_sel_t src, input beat_cnt_t cnt);
        logic taken;
        cfg_info = '0;
        cfg_info[`CFG_WIDTH-1 -: 32] = take_bits(32);
        cfg_info[`CFG_OP_MSB:`CFG_OP_LSB] = op;
        cfg_info[`CFG_SRC_MSB:`CFG_SRC_LSB] = src;
        cfg_info[`CFG_CNT_MSB:`CFG_CNT_LSB] = cnt;
        cfg_vld = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = cfg_rdy;
            #1;
            if (!taken) out_rdy = take_bit();
        end
        cfg_vld = 1'b0;
    endtask

    // Random back-pressure and fresh bank data every cycle
    task automatic finish_frame();
        logic open_now;
        open_now = 1'b1;
        while (open_now) begin
            @(posedge clk);
            open_now = frame_open;
            #1;
            out_rdy = take_bit();
            fill_banks();
        end
    endtask

    task automatic wait_for_valid();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = out_vld;
            #1;
        end
    endtask

    // ==============================
    // Reference model
    // ==============================
    always @(posedge clk or negedge rst_n) begin
        mon_word_t snap;
        int        nb;
        if (!rst_n) begin
            exp_q.delete();
            frame_open <= 1'b0;
            flush_due  <= 1'b0;
            load_age   <= 0;
            exp_have   <= 1'b0;
            exp_dat    <= '0;
            exp_last   <= 1'b0;
        end else begin
            // A taken beat pops the queue and the last one closes the frame
            if (out_vld && out_rdy && (exp_q.size() != 0)) begin
                if (exp_q.size() == 1) begin
                    frame_open <= 1'b0;
                end
                void'(exp_q.pop_front());
            end
            // Abort lands one edge after acceptance
            if (flush_due) begin
                exp_q.delete();
                frame_open <= 1'b0;
            end
            // Bank as seen two edges after the START
            if ((load_age == 2) && !flush_due) begin
                snap = bank_word(pend_src);
                nb   = (pend_cnt == '0) ? `MON_MAX_BEATS : int'(pend_cnt);
                for (int i = 0; i < nb; i++) begin
                    exp_q.push_back(snap[i*`PORT_WIDTH +: `PORT_WIDTH]);
                end
            end
            load_age  <= (load_age == 1) ? 2 : 0;
            flush_due <= cfg_vld && cfg_rdy && (cfg_op == OP_ABORT) && frame_open;
            if (cfg_vld && cfg_rdy && (cfg_op == OP_START)) begin
                frame_open <= 1'b1;
                pend_src   <= cfg_info[`CFG_SRC_MSB:`CFG_SRC_LSB];
                pend_cnt   <= cfg_info[`CFG_CNT_MSB:`CFG_CNT_LSB];
                load_age   <= 1;
            end
            exp_have <= (exp_q.size() != 0);
            exp_last <= (exp_q.size() == 1);
            if (exp_q.size() != 0) exp_dat <= exp_q[0];
        end
    end

    // Previous cycle view of the beat port
    always @(posedge clk) begin
        prev_stall <= out_vld && !out_rdy;
        prev_dat   <= out_dat;
        prev_last  <= out_last;
    end

    // ==============================
    // Checks
    // ==============================
    // Expected {out_vld, out_last, cfg_rdy} right out of reset
    reset_state_check: assert property (@(posedge clk) $rose(rst_n) |->
        (!out_vld && !out_last && cfg_rdy))
        else fail_value("reset_state", 3'b001, $sampled({out_vld, out_last, cfg_rdy}));
    stray_beat_check: assert property (@(posedge clk) disable iff (!rst_n)
        (out_vld && out_rdy) |-> exp_have)
        else stop_run("A beat arrived that no frame expected");
    beat_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (out_vld && out_rdy && exp_have) |-> (out_dat == exp_dat))
        else fail_value("beat_data", $sampled(exp_dat), $sampled(out_dat));
    beat_last_check: assert property (@(posedge clk) disable iff (!rst_n)
        (out_vld && out_rdy && exp_have) |-> (out_last == exp_last))
        else fail_value("beat_last", $sampled(exp_last), $sampled(out_last));
    frame_end_check: assert property (@(posedge clk) disable iff (!rst_n)
        (out_vld && out_rdy && out_last) |=> (!out_vld && cfg_rdy))
        else fail_value("frame_end", 2'b01, $sampled({out_vld, cfg_rdy}));
    idle_vld_check: assert property (@(posedge clk) disable iff (!rst_n)
        !frame_open |-> !out_vld)
        else fail_value("idle_vld", 1'b0, $sampled(out_vld));
    stall_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> (!out_vld || (out_dat == prev_dat)))
        else fail_value("stall_data", $sampled(prev_dat), $sampled(out_dat));
    stall_last_check: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> (!out_vld || (out_last == prev_last)))
        else fail_value("stall_last", $sampled(prev_last), $sampled(out_last));
    // Expected {out_vld, cfg_rdy} two edges after ABORT
    abort_stop_check: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_vld && cfg_rdy && (cfg_op == OP_ABORT) && frame_open) |-> ##2
        (!out_vld && cfg_rdy))
        else fail_value("abort_stop", 2'b01, $sampled({out_vld, cfg_rdy}));
    busy_rdy_check: assert property (@(posedge clk) disable iff (!rst_n)
        (frame_open && cfg_vld && (cfg_op == OP_START)) |-> !cfg_rdy)
        else fail_value("busy_rdy", 1'b0, $sampled(cfg_rdy));
    idle_rdy_check: assert property (@(posedge clk) disable iff (!rst_n)
        !frame_open |-> cfg_rdy)
        else fail_value("idle_rdy", 1'b1, $sampled(cfg_rdy));

    // ==============================
    // Stimulus
    // ==============================
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("Timeout, the frames did not complete in time");
    end

    initial begin : stimulus
        lfsr     = 16'd20;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cfg_vld  = 1'b0;
        cfg_info = '0;
        out_rdy  = 1'b0;
        fill_banks();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Every source with every count under a random sink
        for (int s = 0; s < `MON_SRC_NUM; s++) begin
            for (int c = 0; c <= `MON_MAX_BEATS; c++) begin
                send_cfg(OP_START, src_sel_t'(s), beat_cnt_t'(c));
                finish_frame();
            end
        end
        // Abort with the sink stalled after one beat
        out_rdy = 1'b0;
        send_cfg(OP_START, 2'd2, 2'd3);
        wait_for_valid();
        out_rdy = 1'b1;
        @(posedge clk);
        #1;
        out_rdy = 1'b0;
        send_cfg(OP_ABORT, 2'd0, 2'd0);
        finish_frame();
        send_cfg(OP_START, 2'd2, 2'd0);
        finish_frame();
        // Abort racing a sink that is always ready
        out_rdy = 1'b1;
        send_cfg(OP_START, 2'd3, 2'd0);
        wait_for_valid();
        send_cfg(OP_ABORT, 2'd1, 2'd1);
        finish_frame();
        send_cfg(OP_START, 2'd0, 2'd1);
        finish_frame();
        // START held off by a running frame
        out_rdy = 1'b0;
        send_cfg(OP_START, 2'd1, 2'd2);
        send_cfg(OP_START, 2'd3, 2'd0);
        finish_frame();
        // Words that must not open a frame
        send_cfg(OP_NOP, 2'd2, 2'd1);
        send_cfg(OP_RSVD, 2'd1, 2'd3);
        send_cfg(OP_ABORT, 2'd0, 2'd0);
        repeat (20) begin
            @(posedge clk);
            #1;
            out_rdy = take_bit();
        end
        if ((exp_q.size() == 0) && !frame_open) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_run("Expected beats were still pending at the end of the run");
        end
    end

endmodule

// ==== monitor_top.f ====
+incdir+design
design/monitor_pkg.sv
design/mon_cfg_regs.sv
design/mon_ctrl.sv
design/mon_piso.sv
design/monitor_top.sv
verification/monitor_tb.sv
